//--- Bender.yml
package:
  name: exec_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/exec_pkg.sv
      - rtl/fu_dispatch.sv
      - rtl/alu_unit.sv
      - rtl/booth_mult.sv
      - rtl/nrd_div.sv
      - rtl/cdb_arbiter.sv
      - rtl/exec_core.sv
  - target: simulation
    files:
      - tb/exec_core_properties.sv
      - tb/exec_core_tb.sv

//--- build.f
+incdir+rtl
rtl/exec_pkg.sv
rtl/fu_dispatch.sv
rtl/alu_unit.sv
rtl/booth_mult.sv
rtl/nrd_div.sv
rtl/cdb_arbiter.sv
rtl/exec_core.sv
tb/exec_core_properties.sv
tb/exec_core_tb.sv

//--- rtl/alu_unit.sv
////////////////////////////////////////////////////////////
// Adder and branch comparator
// Single-cycle compute, result held until CDB grant
////////////////////////////////////////////////////////////

`default_nettype none

module alu_unit (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              req_valid_i,
    input  exec_pkg::fu_req_s req_i,
    output logic              ready_o,
    output logic              res_valid_o,
    output exec_pkg::fu_res_s res_o,
    input  logic              grant_i
);

    exec_pkg::fu_res_s res_q;   // Held result
    exec_pkg::fu_res_s res_nx;  // Computed result
    logic              valid_q; // Result waiting for grant
    logic              eq;      // vj == vk
    logic              lt;      // Signed vj < vk

    assign eq = (req_i.vj == req_i.vk);
    assign lt = ($signed(req_i.vj) < $signed(req_i.vk));

    always_comb begin
        res_nx.tag   = req_i.tag;
        res_nx.value = '0; // Branches report zero
        res_nx.taken = 1'b0;
        case (req_i.op)
            exec_pkg::OP_ADD: res_nx.value = req_i.vj + req_i.vk; // Wraps at 32 bits
            exec_pkg::OP_SUB: res_nx.value = req_i.vj - req_i.vk;
            exec_pkg::OP_BEQ: res_nx.taken = eq;
            exec_pkg::OP_BNE: res_nx.taken = ~eq;
            exec_pkg::OP_BLT: res_nx.taken = lt;
            exec_pkg::OP_BGE: res_nx.taken = ~lt;
            default:          res_nx.taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (req_valid_i && ready_o) begin
            valid_q <= 1'b1;
        end else if (grant_i) begin
            valid_q <= 1'b0; // Taken by CDB
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && ready_o) begin
            res_q <= res_nx;
        end
    end

    assign ready_o     = ~valid_q; // Empty holding register
    assign res_valid_o = valid_q;
    assign res_o       = res_q;

endmodule

`default_nettype wire

//--- rtl/booth_mult.sv
////////////////////////////////////////////////////////////
// Radix-2 Booth multiplier
// Signed 32x32, one recoding step per cycle, held result
////////////////////////////////////////////////////////////

`default_nettype none

`include "exec_settings.svh"

module booth_mult (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              req_valid_i,
    input  exec_pkg::fu_req_s req_i,
    output logic              ready_o,
    output logic              res_valid_o,
    output exec_pkg::fu_res_s res_o,
    input  logic              grant_i
);

    exec_pkg::seq_state_e state_q;
    logic [5:0]           cnt_q;    // Step counter
    logic [`EXEC_XLEN:0]  acc_q;    // Upper partial product, one guard bit
    logic [`EXEC_XLEN:0]  mcand_q;  // Sign-extended multiplicand
    logic [`EXEC_XLEN:0]  acc_nx;
    exec_pkg::word_t      mplr_q;   // Multiplier, becomes low product
    logic                 q_m1_q;   // Booth bit right of LSB
    exec_pkg::rob_tag_t   tag_q;
    exec_pkg::op_t        op_q;
    exec_pkg::dword_t     prod;
    exec_pkg::fu_res_s    res_q;
    logic                 last;     // All steps done

    always_comb begin
        case ({mplr_q[0], q_m1_q})
            2'b01:   acc_nx = acc_q + mcand_q; // End of a run of ones
            2'b10:   acc_nx = acc_q - mcand_q; // Start of a run of ones
            default: acc_nx = acc_q;
        endcase
    end

    assign prod = {acc_q[`EXEC_XLEN-1:0], mplr_q};
    assign last = (cnt_q == 6'(`EXEC_XLEN));

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            state_q <= exec_pkg::IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                exec_pkg::IDLE: if (req_valid_i) begin
                    state_q <= exec_pkg::BUSY;
                    cnt_q   <= '0;
                end
                exec_pkg::BUSY: if (last) state_q <= exec_pkg::DONE;
                    else cnt_q <= cnt_q + 6'd1;
                exec_pkg::DONE: if (grant_i) state_q <= exec_pkg::IDLE;
                default: state_q <= exec_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == exec_pkg::IDLE && req_valid_i) begin
            acc_q   <= '0;
            mcand_q <= {req_i.vj[`EXEC_XLEN-1], req_i.vj};
            mplr_q  <= req_i.vk;
            q_m1_q  <= 1'b0;
            tag_q   <= req_i.tag;
            op_q    <= req_i.op;
        end else if (state_q == exec_pkg::BUSY && !last) begin
            acc_q  <= {acc_nx[`EXEC_XLEN], acc_nx[`EXEC_XLEN:1]}; // Arithmetic shift
            mplr_q <= {acc_nx[0], mplr_q[`EXEC_XLEN-1:1]};
            q_m1_q <= mplr_q[0];
        end else if (state_q == exec_pkg::BUSY) begin
            res_q.tag   <= tag_q;
            res_q.value <= (op_q == exec_pkg::OP_MULH) ? prod[2*`EXEC_XLEN-1:`EXEC_XLEN]
                                                       : prod[`EXEC_XLEN-1:0];
            res_q.taken <= 1'b0;
        end
    end

    assign ready_o     = (state_q == exec_pkg::IDLE);
    assign res_valid_o = (state_q == exec_pkg::DONE);
    assign res_o       = res_q;

endmodule

`default_nettype wire

//--- rtl/cdb_arbiter.sv
////////////////////////////////////////////////////////////
// CDB arbiter
// Fixed priority ALU, mul, div; one broadcast per cycle
////////////////////////////////////////////////////////////

`default_nettype none

module cdb_arbiter (
    input  logic              alu_valid_i,
    input  logic              mul_valid_i,
    input  logic              div_valid_i,
    input  exec_pkg::fu_res_s alu_res_i,
    input  exec_pkg::fu_res_s mul_res_i,
    input  exec_pkg::fu_res_s div_res_i,
    output logic              alu_grant_o,
    output logic              mul_grant_o,
    output logic              div_grant_o,
    output exec_pkg::cdb_s    cdb_o
);

    exec_pkg::fu_res_s sel_res; // Winner's result

    always_comb begin
        alu_grant_o = 1'b0;
        mul_grant_o = 1'b0;
        div_grant_o = 1'b0;
        sel_res     = '0;
        if (alu_valid_i) begin
            alu_grant_o = 1'b1; // Short ops first
            sel_res     = alu_res_i;
        end else if (mul_valid_i) begin
            mul_grant_o = 1'b1;
            sel_res     = mul_res_i;
        end else if (div_valid_i) begin
            div_grant_o = 1'b1;
            sel_res     = div_res_i;
        end
    end

    // Grant doubles as the unit's yumi
    assign cdb_o.valid = alu_valid_i | mul_valid_i | div_valid_i;
    assign cdb_o.tag   = sel_res.tag;
    assign cdb_o.value = sel_res.value;
    assign cdb_o.taken = sel_res.taken;

endmodule

`default_nettype wire

//--- rtl/exec_core.sv
////////////////////////////////////////////////////////////
// Execute and write-back core
// Dispatcher, ALU, multiplier, divider and CDB arbiter
////////////////////////////////////////////////////////////

`default_nettype none

module exec_core (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             issue_valid_i,
    input  exec_pkg::issue_s issue_i,
    output logic             issue_ready_o,
    output exec_pkg::cdb_s   cdb_o
);

    exec_pkg::fu_req_s req;             // Shared request fields
    exec_pkg::fu_res_s alu_res, mul_res, div_res;
    logic alu_req_v, mul_req_v, div_req_v; // Dispatch valid per unit
    logic alu_rdy, mul_rdy, div_rdy;
    logic alu_res_v, mul_res_v, div_res_v;
    logic alu_gnt, mul_gnt, div_gnt;    // Yumi from arbiter

    fu_dispatch dispatch_inst (
        .clk_i(clk_i), .reset_i(reset_i),
        .issue_valid_i(issue_valid_i), .issue_i(issue_i), .issue_ready_o(issue_ready_o),
        .alu_ready_i(alu_rdy), .mul_ready_i(mul_rdy), .div_ready_i(div_rdy),
        .alu_valid_o(alu_req_v), .mul_valid_o(mul_req_v), .div_valid_o(div_req_v),
        .req_o(req)
    );

    alu_unit alu_inst (
        .clk_i(clk_i), .reset_i(reset_i), .req_valid_i(alu_req_v), .req_i(req),
        .ready_o(alu_rdy), .res_valid_o(alu_res_v), .res_o(alu_res), .grant_i(alu_gnt)
    );

    booth_mult mul_inst (
        .clk_i(clk_i), .reset_i(reset_i), .req_valid_i(mul_req_v), .req_i(req),
        .ready_o(mul_rdy), .res_valid_o(mul_res_v), .res_o(mul_res), .grant_i(mul_gnt)
    );

    nrd_div div_inst (
        .clk_i(clk_i), .reset_i(reset_i), .req_valid_i(div_req_v), .req_i(req),
        .ready_o(div_rdy), .res_valid_o(div_res_v), .res_o(div_res), .grant_i(div_gnt)
    );

    cdb_arbiter arb_inst (
        .alu_valid_i(alu_res_v), .mul_valid_i(mul_res_v), .div_valid_i(div_res_v),
        .alu_res_i(alu_res), .mul_res_i(mul_res), .div_res_i(div_res),
        .alu_grant_o(alu_gnt), .mul_grant_o(mul_gnt), .div_grant_o(div_gnt),
        .cdb_o(cdb_o)
    );

endmodule

`default_nettype wire

//--- rtl/exec_pkg.sv
////////////////////////////////////////////////////////////
// Execute back end types
// Word and tag vectors, sequencer states, bus structs
////////////////////////////////////////////////////////////

`default_nettype none

`include "exec_settings.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0]      word_t;    // Operand or result
    typedef logic [2*`EXEC_XLEN-1:0]    dword_t;   // Full product
    typedef logic [`EXEC_ROB_TAG_W-1:0] rob_tag_t; // ROB entry index
    typedef logic [`EXEC_FU_W-1:0]      fu_sel_t;  // Target unit
    typedef logic [`EXEC_OP_W-1:0]      op_t;      // Per-unit op code

    localparam fu_sel_t FU_ALU = 2'd1;
    localparam fu_sel_t FU_MUL = 2'd2;
    localparam fu_sel_t FU_DIV = 2'd3;

    localparam op_t OP_ADD  = 3'd0; // ALU ops
    localparam op_t OP_SUB  = 3'd1;
    localparam op_t OP_BEQ  = 3'd2;
    localparam op_t OP_BNE  = 3'd3;
    localparam op_t OP_BLT  = 3'd4;
    localparam op_t OP_BGE  = 3'd5;
    localparam op_t OP_MULH = 3'd1; // High word of product
    localparam op_t OP_REM  = 3'd1; // Remainder instead of quotient

    typedef enum logic [1:0] {IDLE, BUSY, DONE} seq_state_e; // Mul and div sequencer

    typedef struct packed {rob_tag_t tag; fu_sel_t fu; op_t op; word_t vj; word_t vk;} issue_s;

    typedef struct packed {rob_tag_t tag; op_t op; word_t vj; word_t vk;} fu_req_s;

    typedef struct packed {rob_tag_t tag; word_t value; logic taken;} fu_res_s;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
        logic     taken; // Branch outcome
    } cdb_s;

endpackage

`default_nettype wire

//--- rtl/exec_settings.svh
////////////////////////////////////////////////////////////
// Execute back end settings
// Word, tag, op-select and unit-select widths
////////////////////////////////////////////////////////////

`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Data word width
`define EXEC_XLEN 32

`define EXEC_ROB_TAG_W 4 // Reorder buffer tag width

`define EXEC_OP_W 3 // Operation select width

`define EXEC_FU_W 2 // Functional unit selector width

`endif

//--- rtl/fu_dispatch.sv
////////////////////////////////////////////////////////////
// Functional unit dispatcher
// One-entry issue register steering ops to their unit
////////////////////////////////////////////////////////////

`default_nettype none

module fu_dispatch (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             issue_valid_i,
    input  exec_pkg::issue_s issue_i,
    output logic             issue_ready_o,
    input  logic             alu_ready_i,
    input  logic             mul_ready_i,
    input  logic             div_ready_i,
    output logic             alu_valid_o,
    output logic             mul_valid_o,
    output logic             div_valid_o,
    output exec_pkg::fu_req_s req_o
);

    exec_pkg::issue_s issue_q; // Held operation
    logic             full_q;  // Register occupied
    logic             tgt_ready; // Ready of the selected unit
    logic             move;      // Op leaves this cycle
    logic             accept;    // New op enters this cycle

    always_comb begin
        case (issue_q.fu)
            exec_pkg::FU_ALU: tgt_ready = alu_ready_i;
            exec_pkg::FU_MUL: tgt_ready = mul_ready_i;
            exec_pkg::FU_DIV: tgt_ready = div_ready_i;
            default:          tgt_ready = 1'b0; // Code 0 never dispatched
        endcase
    end

    assign move          = full_q & tgt_ready;
    assign issue_ready_o = ~full_q | move; // Empty or draining
    assign accept        = issue_valid_i & issue_ready_o;

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            full_q <= 1'b0;
        end else if (accept) begin
            full_q <= 1'b1; // Refill, even while draining
        end else if (move) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            issue_q <= issue_i; // Payload only
        end
    end

    // Decode unit select into per-unit valid
    assign alu_valid_o = full_q & (issue_q.fu == exec_pkg::FU_ALU);
    assign mul_valid_o = full_q & (issue_q.fu == exec_pkg::FU_MUL);
    assign div_valid_o = full_q & (issue_q.fu == exec_pkg::FU_DIV);

    assign req_o.tag = issue_q.tag; // Shared by all units
    assign req_o.op  = issue_q.op;
    assign req_o.vj  = issue_q.vj;
    assign req_o.vk  = issue_q.vk;

endmodule

`default_nettype wire

//--- rtl/nrd_div.sv
////////////////////////////////////////////////////////////
// Non-restoring divider
// Signed div and rem on magnitudes, sign fixed at end
////////////////////////////////////////////////////////////

`default_nettype none

`include "exec_settings.svh"

module nrd_div (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              req_valid_i,
    input  exec_pkg::fu_req_s req_i,
    output logic              ready_o,
    output logic              res_valid_o,
    output exec_pkg::fu_res_s res_o,
    input  logic              grant_i
);

    exec_pkg::seq_state_e state_q;
    logic [5:0]           cnt_q;     // Step counter
    logic [`EXEC_XLEN:0]  rem_q;     // Signed partial remainder
    logic [`EXEC_XLEN:0]  dvs_q;     // Divisor magnitude
    logic [`EXEC_XLEN:0]  rem_sh;
    logic [`EXEC_XLEN:0]  rem_nx;
    exec_pkg::word_t      quo_q;     // Dividend bits in, quotient bits out
    exec_pkg::word_t      dvd_q;     // Original dividend
    logic                 dvd_neg_q;
    logic                 dvs_neg_q;
    exec_pkg::rob_tag_t   tag_q;
    exec_pkg::op_t        op_q;
    exec_pkg::word_t      quo_fix;   // Signed, corner-corrected quotient
    exec_pkg::word_t      rem_fix;
    exec_pkg::fu_res_s    res_q;
    logic                 iter;      // Division step this cycle
    logic                 last;      // Sign correction cycle

    assign rem_sh = {rem_q[`EXEC_XLEN-1:0], quo_q[`EXEC_XLEN-1]};
    assign rem_nx = rem_q[`EXEC_XLEN] ? rem_sh + dvs_q : rem_sh - dvs_q; // Add back if negative
    assign iter   = (state_q == exec_pkg::BUSY) && (cnt_q < 6'(`EXEC_XLEN));
    assign last   = (cnt_q == 6'(`EXEC_XLEN + 1));

    always_comb begin
        quo_fix = (dvd_neg_q ^ dvs_neg_q) ? -quo_q : quo_q;
        rem_fix = dvd_neg_q ? -rem_q[`EXEC_XLEN-1:0] : rem_q[`EXEC_XLEN-1:0]; // Dividend sign
        if (dvs_q == '0) begin
            quo_fix = '1; // Divide by zero
            rem_fix = dvd_q;
        end else if (dvs_neg_q && dvs_q == 1 && dvd_q == {1'b1, {(`EXEC_XLEN-1){1'b0}}}) begin
            quo_fix = dvd_q; // Most negative by minus one
            rem_fix = '0;
        end
    end

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            state_q <= exec_pkg::IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                exec_pkg::IDLE: if (req_valid_i) begin
                    state_q <= exec_pkg::BUSY;
                    cnt_q   <= '0;
                end
                exec_pkg::BUSY: if (last) state_q <= exec_pkg::DONE;
                    else cnt_q <= cnt_q + 6'd1;
                exec_pkg::DONE: if (grant_i) state_q <= exec_pkg::IDLE;
                default: state_q <= exec_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == exec_pkg::IDLE && req_valid_i) begin
            dvd_q     <= req_i.vj;
            dvd_neg_q <= req_i.vj[`EXEC_XLEN-1];
            dvs_neg_q <= req_i.vk[`EXEC_XLEN-1];
            quo_q     <= req_i.vj[`EXEC_XLEN-1] ? -req_i.vj : req_i.vj; // Magnitudes
            dvs_q     <= {1'b0, req_i.vk[`EXEC_XLEN-1] ? -req_i.vk : req_i.vk};
            rem_q     <= '0;
            tag_q     <= req_i.tag;
            op_q      <= req_i.op;
        end else if (iter) begin
            rem_q <= rem_nx;
            quo_q <= {quo_q[`EXEC_XLEN-2:0], ~rem_nx[`EXEC_XLEN]};
        end else if (state_q == exec_pkg::BUSY && !last) begin
            if (rem_q[`EXEC_XLEN]) rem_q <= rem_q + dvs_q; // Final remainder restore
        end else if (state_q == exec_pkg::BUSY) begin
            res_q.tag   <= tag_q;
            res_q.value <= (op_q == exec_pkg::OP_REM) ? rem_fix : quo_fix;
            res_q.taken <= 1'b0;
        end
    end

    assign ready_o     = (state_q == exec_pkg::IDLE);
    assign res_valid_o = (state_q == exec_pkg::DONE);
    assign res_o       = res_q;

endmodule

`default_nettype wire

//--- tb/exec_core_properties.sv
////////////////////////////////////////////////////////////
// Execute core assertions
// Grant, CDB and dispatch stall rules, bound to exec_core
////////////////////////////////////////////////////////////

`default_nettype none

module exec_core_properties (
    input logic       clk_i,
    input logic       reset_i,
    input logic [2:0] grant_i,          // ALU, mul, div
    input logic [2:0] res_valid_i,      // Same order as grants
    input logic       cdb_valid_i,
    input logic       issue_ready_i,
    input logic [2:0] unit_req_i,       // Dispatcher request per unit
    input logic [2:0] unit_ready_i      // Unit can take a request
);

    timeunit 1ns;
    timeprecision 1ps;

    bit   one_grant_f;   // Set once its assertion fails
    bit   grant_valid_f;
    bit   cdb_known_f;
    bit   stall_f;
    logic any_fail;

    assign any_fail = one_grant_f | grant_valid_f | cdb_known_f | stall_f;

    one_grant_a: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(grant_i))
        else begin
            $error("More than one CDB grant in a cycle");
            one_grant_f = 1'b1;
        end

    grant_valid_a: assert property (@(posedge clk_i) disable iff (reset_i)
        (grant_i & ~res_valid_i) == 3'b000)
        else begin
            $error("Grant to a unit without a held result");
            grant_valid_f = 1'b1;
        end

    cdb_known_a: assert property (@(posedge clk_i) disable iff (reset_i)
        !$isunknown(cdb_valid_i))
        else begin
            $error("CDB valid is unknown");
            cdb_known_f = 1'b1;
        end

    // Held op whose unit is busy must block new issues
    stall_a: assert property (@(posedge clk_i) disable iff (reset_i)
        ((unit_req_i & ~unit_ready_i) != 3'b000) |-> !issue_ready_i)
        else begin
            $error("Issue ready while dispatcher is blocked");
            stall_f = 1'b1;
        end

endmodule

bind exec_core exec_core_properties props_inst (
    .clk_i(clk_i), .reset_i(reset_i),
    .grant_i({alu_gnt, mul_gnt, div_gnt}), .res_valid_i({alu_res_v, mul_res_v, div_res_v}),
    .cdb_valid_i(cdb_o.valid), .issue_ready_i(issue_ready_o),
    .unit_req_i({alu_req_v, mul_req_v, div_req_v}), .unit_ready_i({alu_rdy, mul_rdy, div_rdy})
);

`default_nettype wire

//--- tb/exec_core_tb.sv
////////////////////////////////////////////////////////////
// Execute core testbench
// Directed ALU, mul, div and mixed tests, CDB scoreboard
////////////////////////////////////////////////////////////

`default_nettype none

module exec_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 2;  // Input skew after rising edge
    localparam int RESET_CYCLES = 10;
    localparam int N_TAGS       = 1 << $bits(exec_pkg::rob_tag_t);
    localparam int N_RAND       = 6;  // Random pairs per test
    localparam int N_OPS        = 2 * 8 + 4 * N_RAND + 2 * N_RAND + 8 + 2 * N_RAND + 4 + 16;
    localparam int WATCHDOG_CYCLES = N_OPS * 100 + 500; // Margin for reset and drains
    localparam int DRAIN_LIMIT  = 200;

    logic               clk_i;
    logic               reset_i;
    logic               issue_valid_i;
    exec_pkg::issue_s   issue_i;
    logic               issue_ready_o;
    exec_pkg::cdb_s     cdb_o;

    integer             seed = 32'hbc6;
    logic [32:0]        exp_res [N_TAGS];     // {taken, value} per tag
    logic               exp_pending [N_TAGS]; // Tag in flight
    exec_pkg::rob_tag_t next_tag;
    int                 issued_cnt;
    int                 retired_cnt;

    exec_core UUT (
        .clk_i(clk_i), .reset_i(reset_i),
        .issue_valid_i(issue_valid_i), .issue_i(issue_i), .issue_ready_o(issue_ready_o),
        .cdb_o(cdb_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic stop_with_error(input string why);
        $display("ERROR %0t ns: %s", $time, why);
        $display("TB FAILED");
        $fatal(1, why);
    endtask

    task automatic compare_values(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Reference model: returns {taken, value}
    function automatic logic [32:0] model_op(input exec_pkg::fu_sel_t fu, input exec_pkg::op_t op,
                                             input exec_pkg::word_t a, input exec_pkg::word_t b);
        int              sa;
        int              sb;
        longint          p;
        exec_pkg::word_t q;
        exec_pkg::word_t r;
        sa = a;
        sb = b;
        p  = longint'(sa) * longint'(sb); // Full signed product
        if (fu == exec_pkg::FU_ALU) begin
            case (op)
                exec_pkg::OP_ADD: return {1'b0, a + b};
                exec_pkg::OP_SUB: return {1'b0, a - b};
                exec_pkg::OP_BEQ: return {a == b, 32'h0};
                exec_pkg::OP_BNE: return {a != b, 32'h0};
                exec_pkg::OP_BLT: return {sa < sb, 32'h0};
                default:          return {sa >= sb, 32'h0};
            endcase
        end else if (fu == exec_pkg::FU_MUL) begin
            return (op == exec_pkg::OP_MULH) ? {1'b0, p[63:32]} : {1'b0, p[31:0]};
        end
        if (b == 32'h0) begin
            q = '1;         // Divide by zero
            r = a;
        end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            q = a;          // Overflow case
            r = '0;
        end else begin
            q = sa / sb;    // Truncates toward zero
            r = sa % sb;    // Sign of dividend
        end
        return {1'b0, (op == exec_pkg::OP_REM) ? r : q};
    endfunction

    // Hold the op until accepted, then log its expected result
    task automatic issue_op(input exec_pkg::fu_sel_t fu, input exec_pkg::op_t op,
                            input exec_pkg::word_t a, input exec_pkg::word_t b);
        exec_pkg::rob_tag_t tag;
        tag = next_tag;
        if (exp_pending[tag]) stop_with_error("ROB tag reused while its result is in flight");
        issue_i.tag   = tag;
        issue_i.fu    = fu;
        issue_i.op    = op;
        issue_i.vj    = a;
        issue_i.vk    = b;
        issue_valid_i = 1'b1;
        do @(negedge clk_i); while (!issue_ready_o); // Stall only while not ready
        exp_res[tag]     = model_op(fu, op, a, b);
        exp_pending[tag] = 1'b1;
        issued_cnt++;
        next_tag++;
        @(posedge clk_i);
        #DRIVE_DLY;
        issue_valid_i = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        @(posedge clk_i);
        while (issued_cnt != retired_cnt && n < DRAIN_LIMIT) begin
            @(posedge clk_i);
            n++;
        end
        #DRIVE_DLY;
    endtask

    task automatic reset_state_check();
        @(negedge clk_i);
        compare_values("cdb valid after reset", 32'(cdb_o.valid), 32'h0);
        compare_values("issue ready after reset", 32'(issue_ready_o), 32'h1);
        @(posedge clk_i);
        #DRIVE_DLY;
    endtask

    task automatic alu_ops();
        exec_pkg::word_t a;
        exec_pkg::word_t b;
        for (int i = 0; i < 8; i++) begin
            a = $random(seed);
            b = $random(seed);
            issue_op(exec_pkg::FU_ALU, exec_pkg::OP_ADD, a, b);
            issue_op(exec_pkg::FU_ALU, exec_pkg::OP_SUB, a, b);
        end
        for (int i = 0; i < N_RAND; i++) begin
            a = $random(seed);
            b = (i % 2 == 0) ? a : $random(seed); // Every other pair equal
            if (i == 1) begin
                a = 32'hffff_ffff; // Signed and unsigned order differ
                b = 32'h0000_0001;
            end else if (i == 3) begin
                a = 32'h8000_0000;
                b = 32'h7fff_ffff;
            end
            for (int op = exec_pkg::OP_BEQ; op <= exec_pkg::OP_BGE; op++) begin
                issue_op(exec_pkg::FU_ALU, exec_pkg::op_t'(op), a, b);
            end
        end
    endtask

    task automatic mult_ops();
        exec_pkg::word_t a;
        exec_pkg::word_t b;
        exec_pkg::word_t ext [8] = '{32'h8000_0000, 32'h8000_0000, 32'h8000_0000, 32'hffff_ffff,
                                     32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff, 32'hffff_ffff};
        for (int i = 0; i < N_RAND; i++) begin
            a = $random(seed);
            b = $random(seed);
            issue_op(exec_pkg::FU_MUL, exec_pkg::OP_ADD, a, b); // mul
            issue_op(exec_pkg::FU_MUL, exec_pkg::OP_MULH, a, b);
        end
        for (int i = 0; i < 4; i++) begin
            issue_op(exec_pkg::FU_MUL, exec_pkg::OP_ADD, ext[2 * i], ext[2 * i + 1]);
            issue_op(exec_pkg::FU_MUL, exec_pkg::OP_MULH, ext[2 * i], ext[2 * i + 1]);
        end
    endtask

    task automatic div_ops();
        exec_pkg::word_t a;
        exec_pkg::word_t b;
        for (int i = 0; i < N_RAND; i++) begin
            a = $random(seed);
            b = (i < 3) ? $random(seed) : $random(seed) % 1000; // Small divisors too
            issue_op(exec_pkg::FU_DIV, exec_pkg::OP_ADD, a, b); // div
            issue_op(exec_pkg::FU_DIV, exec_pkg::OP_REM, a, b);
        end
        a = $random(seed);
        issue_op(exec_pkg::FU_DIV, exec_pkg::OP_ADD, a, 32'h0);
        issue_op(exec_pkg::FU_DIV, exec_pkg::OP_REM, a, 32'h0);
        issue_op(exec_pkg::FU_DIV, exec_pkg::OP_ADD, 32'h8000_0000, 32'hffff_ffff);
        issue_op(exec_pkg::FU_DIV, exec_pkg::OP_REM, 32'h8000_0000, 32'hffff_ffff);
    endtask

    // Sixteen distinct tags, no idle cycles between issues
    task automatic mixed_stream();
        exec_pkg::fu_sel_t fu;
        exec_pkg::op_t     op;
        for (int i = 0; i < 16; i++) begin
            fu = exec_pkg::fu_sel_t'(1 + i % 3);
            op = (fu == exec_pkg::FU_ALU) ? 3'({$random(seed)} % 6) : 3'({$random(seed)} % 2);
            issue_op(fu, op, $random(seed), $random(seed));
        end
    endtask

    // CDB monitor, one broadcast per cycle at most
    always @(negedge clk_i) begin
        if (!reset_i && cdb_o.valid) begin
            if (!exp_pending[cdb_o.tag]) stop_with_error("CDB broadcast of a tag not in flight");
            compare_values($sformatf("tag %0d value", cdb_o.tag), cdb_o.value,
                           exp_res[cdb_o.tag][31:0]);
            compare_values($sformatf("tag %0d taken", cdb_o.tag), 32'(cdb_o.taken),
                           32'(exp_res[cdb_o.tag][32]));
            exp_pending[cdb_o.tag] = 1'b0;
            retired_cnt++;
        end
    end

    // Bound assertions raise this on their first failure
    always @(posedge UUT.props_inst.any_fail) begin
        stop_with_error("a bound assertion on the core failed");
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR %0t ns: timeout, run did not finish in %0d cycles", $time,
                 WATCHDOG_CYCLES);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk_i         = 1'b0;
        reset_i       = 1'b1;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        next_tag      = '0;
        issued_cnt    = 0;
        retired_cnt   = 0;
        for (int i = 0; i < N_TAGS; i++) exp_pending[i] = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DLY;
        reset_i = 1'b0;
        reset_state_check();
        alu_ops();
        drain();
        mult_ops();
        drain();
        div_ops();
        drain();
        mixed_stream();
        drain();
        if (issued_cnt != retired_cnt) begin
            $display("ERROR %0t ns: %0d results never reached the CDB", $time,
                     issued_cnt - retired_cnt);
            $display("TB FAILED");
            $fatal(1, "scoreboard not empty");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
